// File: build.f
src/approx_mac_pkg.sv
src/approx_mult.sv
src/op_decode.sv
src/mult_execute.sv
src/result_stage.sv
src/approx_mac_top.sv
test/approx_mac_assertions.sv
test/approx_mac_tb.sv

// File: test/approx_mac_stim.txt
# op a b expected_result illegal, all fields hex, one command per line.
# Results are 40-bit two's complement; op 5 to 7 are illegal codes.
4 0000 0000 0000000000 0
0 0003 0005 000000000F 0
0 0007 FFFD FFFFFFFFEB 0
0 FFF6 0064 FFFFFFFC18 0
0 8000 8000 0040000000 0
0 7FFF 7FFF 003FFF0001 0
0 8000 7FFF FFC0008000 0
0 0000 1234 0000000000 0
0 FFFF FFFF 0000000001 0
1 0003 0005 FFFFFF8000 0
1 0041 0003 FFFFFF80C0 0
1 0100 0010 FFFFFF9000 0
1 8000 8000 003FFF8000 0
1 FFC0 0100 FFFFFF4000 0
1 0C00 FFFE FFFFFF6800 0
1 0002 FFFF FFFFFE8040 0
3 0003 0005 000000800F 0
3 0041 0003 0000008003 0
3 8000 8000 0000008000 0
3 0002 FFFF 0000017FBE 0
4 0000 0000 0000000000 0
2 0100 0010 FFFFFF9000 0
2 0003 0005 FFFFFF1000 0
2 8000 8000 003FFE9000 0
2 0041 0003 003FFE10C0 0
5 1234 5678 0000000000 1
7 FFFF FFFF 0000000000 1
2 0000 0000 003FFD90C0 0
4 0000 0000 0000000000 0
2 FFC0 0100 FFFFFF4000 0
6 0000 0000 0000000000 1
2 0C00 FFFE FFFFFEA800 0

// File: test/approx_mac_tb.sv
`timescale 1ns/1ps

module approx_mac_tb;

    localparam int ACC_W      = 40;
    localparam int RST_CYCLES = 8;
    localparam int ACK_BOUND  = 10;   // Cycles allowed for each handshake edge.
    localparam int MAX_VEC    = 64;
    localparam int ACK_LAT    = 4;    // Edge 0 plus three edges to ack.

    logic                    clk;
    logic                    rst_n;
    logic                    req;
    approx_mac_pkg::opcode_t op;
    logic [15:0]             a;
    logic [15:0]             b;
    logic                    ack;
    logic [ACC_W-1:0]        result;
    logic                    illegal;

    logic [2:0]       vec_op  [MAX_VEC];
    logic [15:0]      vec_a   [MAX_VEC];
    logic [15:0]      vec_b   [MAX_VEC];
    logic [ACC_W-1:0] vec_exp [MAX_VEC];
    logic             vec_ill [MAX_VEC];

    int num_vec;
    int errors;
    int checks;
    int assert_fails;
    bit loaded;
    bit stalled;

    approx_mac_top #(
        .ACC_W (ACC_W)
    ) approx_mac_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .op      (op),
        .a       (a),
        .b       (b),
        .ack     (ack),
        .result  (result),
        .illegal (illegal)
    );

    bind result_stage approx_mac_assertions #(
        .ACC_W (ACC_W)
    ) approx_mac_assertions_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .ack     (ack),
        .result  (result),
        .illegal (illegal)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [63:0] f_exp;
        logic [31:0] f_ill;
        fd = $fopen("test/approx_mac_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file test/approx_mac_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") continue;  // Blank or comment.
            n = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_exp, f_ill);
            if (n == 5) begin
                vec_op[num_vec]  = f_op[2:0];
                vec_a[num_vec]   = f_a[15:0];
                vec_b[num_vec]   = f_b[15:0];
                vec_exp[num_vec] = f_exp[ACC_W-1:0];
                vec_ill[num_vec] = f_ill[0];
                num_vec++;
            end
        end
        $fclose(fd);
    endtask

    // One full four-phase command, with req held for a few extra cycles.
    task automatic run_vector(input int idx);
        int               wait_cycles;
        int               exp_lat;
        int               hold;
        logic [ACC_W-1:0] held_result;
        logic             held_illegal;
        exp_lat = (idx == 0) ? ACK_LAT : ACK_LAT + 1;  // Decoder idles one edge after ack falls.
        op  = approx_mac_pkg::opcode_t'(vec_op[idx]);
        a   = vec_a[idx];
        b   = vec_b[idx];
        req = 1'b1;
        wait_cycles = 0;
        do begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end while (!ack && wait_cycles < ACK_BOUND);
        if (!ack) begin
            $display("Vector %0d: ack did not rise within %0d cycles", idx, ACK_BOUND);
            errors++;
            stalled = 1'b1;
            return;
        end
        if (wait_cycles != exp_lat) begin
            $display("Vector %0d: ack rose %0d cycles after req, expected %0d",
                     idx, wait_cycles, exp_lat);
            errors++;
        end
        checks++;
        if (result !== vec_exp[idx] || illegal !== vec_ill[idx]) begin
            errors++;
            $display("ERROR at %0t: vector %0d op %0d a %h b %h expected %h/%0b got %h/%0b",
                     $time, idx, vec_op[idx], vec_a[idx], vec_b[idx],
                     vec_exp[idx], vec_ill[idx], result, illegal);
        end

        hold         = idx % 5;
        held_result  = result;
        held_illegal = illegal;
        repeat (hold) begin
            @(posedge clk);
            #1;
            checks++;
            if (!ack || result !== held_result || illegal !== held_illegal) begin
                errors++;
                $display("ERROR at %0t: vector %0d ack %0b result %h illegal %0b under hold",
                         $time, idx, ack, result, illegal);
            end
        end

        req = 1'b0;
        wait_cycles = 0;
        do begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end while (ack && wait_cycles < ACK_BOUND);
        if (ack) begin
            $display("Vector %0d: ack stayed high %0d cycles after req fell", idx, ACK_BOUND);
            errors++;
            stalled = 1'b1;
        end
    endtask

    initial begin : watchdog
        wait (loaded);
        repeat (num_vec * 20 + RST_CYCLES) @(posedge clk);
        $display("The run timed out before all %0d vectors completed", num_vec);
        $display("TB FAILED");
        $finish;
    end

    initial begin : main
        rst_n        = 1'b0;
        req          = 1'b0;
        op           = approx_mac_pkg::op_mul_exact;
        a            = '0;
        b            = '0;
        errors       = 0;
        checks       = 0;
        num_vec      = 0;
        assert_fails = 0;
        stalled      = 1'b0;
        loaded       = 1'b0;

        load_vectors();
        loaded = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < num_vec && !stalled; i++) begin
            run_vector(i);
        end
        if (num_vec == 0) begin
            $display("No vectors were read from the stimulus file");
            errors++;
        end

        assert_fails = approx_mac_top_inst.result_stage_inst.approx_mac_assertions_inst.fail_count;
        errors += assert_fails;
        $display("Vectors: %0d, checks: %0d, assertion failures: %0d, errors: %0d",
                 num_vec, checks, assert_fails, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: test/approx_mac_assertions.sv
`timescale 1ns/1ps

module approx_mac_assertions #(
    parameter int ACC_W = 40
) (
    input logic             clk,
    input logic             rst_n,
    input logic             req,
    input logic             ack,
    input logic [ACC_W-1:0] result,
    input logic             illegal
);

    int fail_count = 0;  // Failed assertion tally.

    // Ack only answers a pending request.
    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req)
    ) else begin
        fail_count++;
        $error("ack rose while req was low");
    end

    // Once raised, ack waits for the requester to let go.
    ack_holds: assert property (
        @(posedge clk) disable iff (!rst_n) (ack && req) |=> ack
    ) else begin
        fail_count++;
        $error("ack dropped before req was sampled low");
    end

    ack_result_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        ack |=> (!ack || ($stable(result) && $stable(illegal)))
    ) else begin
        fail_count++;
        $error("result or illegal changed while ack was high");
    end

endmodule

// File: src/approx_mac_top.sv
`timescale 1ns/1ps

module approx_mac_top #(
    parameter int ACC_W = 40
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              req,
    input  approx_mac_pkg::opcode_t           op,
    input  logic [approx_mac_pkg::data_w-1:0] a,
    input  logic [approx_mac_pkg::data_w-1:0] b,
    output logic                              ack,
    output logic [ACC_W-1:0]                  result,
    output logic                              illegal
);

    logic                              issue;
    logic [approx_mac_pkg::data_w-1:0] opa;
    logic [approx_mac_pkg::data_w-1:0] opb;
    logic                              sel_approx;
    logic                              acc_en;
    logic                              acc_clr;
    logic                              err_mode;
    logic                              bad_op;
    logic                              done;
    logic [ACC_W-1:0]                  exe_result;
    logic                              exe_bad;

    op_decode op_decode_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .op         (op),
        .a          (a),
        .b          (b),
        .ack        (ack),
        .issue      (issue),
        .opa        (opa),
        .opb        (opb),
        .sel_approx (sel_approx),
        .acc_en     (acc_en),
        .acc_clr    (acc_clr),
        .err_mode   (err_mode),
        .bad_op     (bad_op)
    );

    mult_execute #(
        .ACC_W (ACC_W)
    ) mult_execute_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue      (issue),
        .opa        (opa),
        .opb        (opb),
        .sel_approx (sel_approx),
        .acc_en     (acc_en),
        .acc_clr    (acc_clr),
        .err_mode   (err_mode),
        .bad_op     (bad_op),
        .done       (done),
        .exe_result (exe_result),
        .exe_bad    (exe_bad)
    );

    // Ack also closes the decoder's busy window.
    result_stage #(
        .ACC_W (ACC_W)
    ) result_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .done       (done),
        .exe_result (exe_result),
        .exe_bad    (exe_bad),
        .req        (req),
        .ack        (ack),
        .result     (result),
        .illegal    (illegal)
    );

endmodule

// File: src/result_stage.sv
`timescale 1ns/1ps

module result_stage #(
    parameter int ACC_W = 40
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             done,
    input  logic [ACC_W-1:0] exe_result,
    input  logic             exe_bad,
    input  logic             req,
    output logic             ack,
    output logic [ACC_W-1:0] result,
    output logic             illegal
);

    // Ack handshake and the illegal flag.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack     <= 1'b0;
            illegal <= 1'b0;
        end else if (done) begin
            ack     <= 1'b1;
            illegal <= exe_bad;
        end else if (ack && !req) begin
            ack <= 1'b0;  // Requester has let go.
        end
    end

    // Result holds until the next command completes.
    always_ff @(posedge clk) begin
        if (done) begin
            result <= exe_result;
        end
    end

endmodule

// File: src/mult_execute.sv
`timescale 1ns/1ps

module mult_execute #(
    parameter int ACC_W = 40
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              issue,
    input  logic [approx_mac_pkg::data_w-1:0] opa,
    input  logic [approx_mac_pkg::data_w-1:0] opb,
    input  logic                              sel_approx,
    input  logic                              acc_en,
    input  logic                              acc_clr,
    input  logic                              err_mode,
    input  logic                              bad_op,
    output logic                              done,
    output logic [ACC_W-1:0]                  exe_result,
    output logic                              exe_bad
);

    logic        [approx_mac_pkg::prod_w-1:0] approx_raw;
    logic signed [approx_mac_pkg::prod_w-1:0] exact_p;
    logic signed [approx_mac_pkg::prod_w-1:0] approx_p;
    logic signed [ACC_W-1:0]                  exact_ext;
    logic signed [ACC_W-1:0]                  approx_ext;
    logic signed [ACC_W-1:0]                  acc;
    logic signed [ACC_W-1:0]                  acc_sum;

    approx_mult approx_mult_inst (
        .x (opa),
        .y (opb),
        .z (approx_raw)
    );

    assign exact_p  = $signed(opa) * $signed(opb);
    assign approx_p = $signed(approx_raw);

    // Sign extension to the accumulator width.
    assign exact_ext  = exact_p;
    assign approx_ext = approx_p;
    assign acc_sum    = acc + approx_ext;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
            acc  <= '0;
        end else begin
            done <= issue;
            if (issue && !bad_op) begin
                if (acc_clr) acc <= '0;
                else if (acc_en) acc <= acc_sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            exe_bad <= bad_op;
            if (bad_op || acc_clr) begin
                exe_result <= '0;
            end else if (acc_en) begin
                exe_result <= acc_sum;  // New running total.
            end else if (err_mode) begin
                exe_result <= exact_ext - approx_ext;
            end else if (sel_approx) begin
                exe_result <= approx_ext;
            end else begin
                exe_result <= exact_ext;
            end
        end
    end

endmodule

// File: src/op_decode.sv
`timescale 1ns/1ps

module op_decode (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              req,
    input  approx_mac_pkg::opcode_t           op,
    input  logic [approx_mac_pkg::data_w-1:0] a,
    input  logic [approx_mac_pkg::data_w-1:0] b,
    input  logic                              ack,
    output logic                              issue,
    output logic [approx_mac_pkg::data_w-1:0] opa,
    output logic [approx_mac_pkg::data_w-1:0] opb,
    output logic                              sel_approx,
    output logic                              acc_en,
    output logic                              acc_clr,
    output logic                              err_mode,
    output logic                              bad_op
);

    approx_mac_pkg::decode_state_t state;
    logic ack_seen;  // Ack went high for the command in flight.
    logic accept;
    logic accept_q;  // Operands latched on the previous edge.

    assign accept = (state == approx_mac_pkg::st_idle) && req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= approx_mac_pkg::st_idle;
            issue    <= 1'b0;
            accept_q <= 1'b0;
            ack_seen <= 1'b0;
        end else begin
            accept_q <= accept;
            issue    <= accept_q;
            case (state)
                approx_mac_pkg::st_idle: begin
                    ack_seen <= 1'b0;
                    if (req) state <= approx_mac_pkg::st_busy;
                end
                approx_mac_pkg::st_busy: begin
                    if (ack) begin
                        ack_seen <= 1'b1;
                    end else if (ack_seen) begin
                        state <= approx_mac_pkg::st_idle;  // Handshake closed.
                    end
                end
                default: state <= approx_mac_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opa <= a;
            opb <= b;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_approx <= 1'b0;
            acc_en     <= 1'b0;
            acc_clr    <= 1'b0;
            err_mode   <= 1'b0;
            bad_op     <= 1'b0;
        end else if (accept) begin
            sel_approx <= 1'b0;
            acc_en     <= 1'b0;
            acc_clr    <= 1'b0;
            err_mode   <= 1'b0;
            bad_op     <= 1'b0;
            case (op)
                approx_mac_pkg::op_mul_exact:  ;
                approx_mac_pkg::op_mul_approx: sel_approx <= 1'b1;
                approx_mac_pkg::op_mac_approx: begin
                    sel_approx <= 1'b1;
                    acc_en     <= 1'b1;
                end
                approx_mac_pkg::op_err_dist:   err_mode <= 1'b1;
                approx_mac_pkg::op_acc_clr:    acc_clr  <= 1'b1;
                default:                       bad_op   <= 1'b1;
            endcase
        end
    end

endmodule

// File: src/approx_mult.sv
`timescale 1ns/1ps

module approx_mult (
    input  logic [approx_mac_pkg::data_w-1:0] x,
    input  logic [approx_mac_pkg::data_w-1:0] y,
    output logic [approx_mac_pkg::prod_w-1:0] z
);

    // Baugh-Wooley rows 0 to 14, one per multiplier bit.
    logic [15:0] pp [15];
    // Row 15 carries the inverted magnitude bits and the top constant one.
    logic [16:0] pp_top;
    // Sparse correction vectors standing in for the low columns.
    logic [20:0] cv [6];
    logic [31:0] sum;

    genvar i;
    generate
        for (i = 0; i < 15; i++) begin : g_rows
            assign pp[i] = {~(y[15] & x[i]), y[14:0] & {15{x[i]}}};
        end
    endgenerate

    assign pp_top[14:0] = ~(y[14:0] & {15{x[15]}});
    assign pp_top[15]   = y[15] & x[15];
    assign pp_top[16]   = 1'b1;

    always_comb begin
        for (int k = 0; k < 6; k++) begin
            cv[k] = '0;
        end

        // First vector picks up most of the low-order terms.
        cv[0][3]  = pp[0][2] & pp[1][1];
        cv[0][4]  = pp[2][1] & pp[3][0];
        cv[0][6]  = pp[0][6] ^ pp[1][5];
        cv[0][7]  = pp[2][4] & pp[3][3];
        cv[0][10] = pp[2][8] ^ pp[3][7];
        cv[0][12] = pp[0][11] & pp[1][10];
        cv[0][13] = pp[4][8] & pp[5][7];
        cv[0][14] = pp[2][12] ^ pp[3][11];
        cv[0][15] = pp[0][14] & pp[1][13];
        cv[0][16] = pp[0][15] & pp[1][14];
        cv[0][17] = pp[1][15];
        cv[0][18] = pp[3][15];
        cv[0][19] = pp[4][14] & pp[5][13];
        cv[0][20] = pp[4][15] & pp[5][14];

        cv[1][6]  = pp[2][4] ^ pp[3][3];
        cv[1][13] = pp[4][9] ^ pp[5][8];
        cv[1][15] = pp[4][11] ^ pp[5][10];
        cv[1][17] = pp[2][14] & pp[3][13];
        cv[1][18] = pp[4][13] & pp[5][12];
        cv[1][19] = pp[4][15] ^ pp[5][14];
        cv[1][20] = pp[5][15];

        cv[2][6]  = pp[4][2] ^ pp[5][1];
        cv[2][17] = pp[2][15] & pp[3][14];
        cv[2][18] = pp[4][14] ^ pp[5][13];

        // Remaining vectors each land a single term in column 17.
        cv[3][17] = pp[2][15] ^ pp[3][14];
        cv[4][17] = pp[4][12] ^ pp[5][11];
        cv[5][17] = pp[4][13] ^ pp[5][12];
    end

    always_comb begin
        sum = 32'(pp_top) << 15;
        for (int r = 6; r < 15; r++) begin
            sum = sum + (32'(pp[r]) << r);  // Kept rows, exact weight.
        end
        for (int c = 0; c < 6; c++) begin
            sum = sum + 32'(cv[c]);
        end
    end

    assign z = sum;

endmodule

// File: src/approx_mac_pkg.sv
package approx_mac_pkg;

    // Operand and full product widths. The multiplier is wired for these.
    localparam int data_w = 16;
    localparam int prod_w = 32;

    // Command codes. Codes 5 to 7 are illegal.
    typedef enum logic [2:0] {
        op_mul_exact  = 3'd0,
        op_mul_approx = 3'd1,
        op_mac_approx = 3'd2,  // Accumulate approximate product.
        op_err_dist   = 3'd3,  // Exact minus approximate.
        op_acc_clr    = 3'd4
    } opcode_t;

    // Command acceptance state in the decoder.
    typedef enum logic {
        st_idle = 1'b0,
        st_busy = 1'b1
    } decode_state_t;

endpackage
